/* bench/hdc_tests.txt */
# columns: name kind a b c d e f expected, numbers in hex
# reg a=write flag b=addr c=data, gen a=item_num b=ctrl, bundle a=stall b=count c..f=indices
reg_ctrl_reset   reg    0 0  0  0 0 0 0
reg_num_write    reg    1 4  5  0 0 0 5
reg_num_trunc    reg    1 4  1f 0 0 0 f
reg_unmapped     reg    1 10 a5 0 0 0 0
gen_items_15     gen    f 3  0  0 0 0 2
bundle_single_0  bundle 0 1  0  0 0 0 94dacb7a2b1f4d63
bundle_single_2  bundle 0 1  2  0 0 0 164c87ead28ab0e1
bundle_odd_012   bundle 0 3  0  1 2 0 16d8c77a7b0a59e1
gen_items_1      gen    1 3  0  0 0 0 2
bundle_even_01   bundle 0 2  0  1 0 0 16d8c77a7b0a59e1
stall_single_1   bundle 1 1  1  0 0 0 77b0567e7b0859a0
stall_odd_201    bundle 1 3  2  0 1 0 16d8c77a7b0a59e1
stall_even_10    bundle 1 2  1  0 0 0 16d8c77a7b0a59e1
stall_pair_00    bundle 1 2  0  0 0 0 94dacb7a2b1f4d63

/* bench/tb_hdc_accel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hdc_cfg.svh"

module tb_hdc_accel;

    localparam int TIMEOUT = 200;

    logic                 AXIS_ACLK;
    logic                 S_AXI_ARESETN;
    logic [31:0]          s_axi_awaddr;
    logic                 s_axi_awvalid;
    wire                  s_axi_awready;
    logic [31:0]          s_axi_wdata;
    logic                 s_axi_wvalid;
    wire                  s_axi_wready;
    logic                 s_axi_bready;
    wire  [1:0]           s_axi_bresp;
    wire                  s_axi_bvalid;
    logic [31:0]          s_axi_araddr;
    logic                 s_axi_arvalid;
    wire                  s_axi_arready;
    logic                 s_axi_rready;
    wire  [31:0]          s_axi_rdata;
    wire  [1:0]           s_axi_rresp;
    wire                  s_axi_rvalid;
    logic [`HDC_IN_W-1:0] s_axis_tdata;
    logic                 s_axis_tvalid;
    logic                 s_axis_tlast;
    wire                  s_axis_tready;
    wire  [`HDC_DIM-1:0]  m_axis_tdata;
    wire                  m_axis_tvalid;
    wire                  m_axis_tlast;
    logic                 m_axis_tready;

    // run bookkeeping
    int           errors;
    int           checks;
    int           tests;
    int           errs_before;
    int           polls;
    logic         hung;
    logic [7:0]   lfsr;
    // bresp and rresp of every AXI-Lite transfer in a test, ORed
    logic [1:0]   resp_acc;
    // test file fields
    int           fd;
    int           r;
    logic [1599:0] line;
    logic [255:0] name;
    logic [63:0]  kind;
    logic [31:0]  a;
    logic [31:0]  b;
    logic [31:0]  c;
    logic [31:0]  d;
    logic [31:0]  e;
    logic [31:0]  f;
    logic [63:0]  expv;
    logic [31:0]  rd;
    logic [63:0]  res;
    logic         last;
    logic         leak;

    hdc_accel uut (.*);

    initial AXIS_ACLK = 1'b0;
    always #5 AXIS_ACLK = ~AXIS_ACLK;

    // 8-bit Fibonacci LFSR with taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic check_value(input logic [255:0] tname, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("CHECK FAILED %0s: expected %h, actual %h", tname, exp_v, act_v);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: the DUT did not respond while waiting for %s", what);
        hung = 1'b1;
    endtask

    // --------------------
    // axi-lite master
    // --------------------
    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
        logic aw_ok;
        logic w_ok;
        logic done;
        int   cyc;
        aw_ok = 1'b0;
        w_ok  = 1'b0;
        cyc   = 0;
        @(posedge AXIS_ACLK);
        s_axi_awaddr  <= addr;
        s_axi_awvalid <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wvalid  <= 1'b1;
        // address and data may be taken in either order
        while (!(aw_ok && w_ok) && !hung) begin
            @(negedge AXIS_ACLK);
            if (s_axi_awvalid && s_axi_awready) aw_ok = 1'b1;
            if (s_axi_wvalid && s_axi_wready) w_ok = 1'b1;
            @(posedge AXIS_ACLK);
            if (aw_ok) s_axi_awvalid <= 1'b0;
            if (w_ok) s_axi_wvalid <= 1'b0;
            cyc++;
            if (!(aw_ok && w_ok) && cyc > TIMEOUT) report_timeout("write address and data");
        end
        s_axi_bready <= 1'b1;
        done = 1'b0;
        cyc  = 0;
        while (!done && !hung) begin
            @(negedge AXIS_ACLK);
            done = s_axi_bvalid;
            if (done) resp_acc = resp_acc | s_axi_bresp;
            @(posedge AXIS_ACLK);
            cyc++;
            if (!done && cyc > TIMEOUT) report_timeout("the write response");
        end
        s_axi_bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
        logic done;
        int   cyc;
        data = '0;
        done = 1'b0;
        cyc  = 0;
        @(posedge AXIS_ACLK);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        while (!done && !hung) begin
            @(negedge AXIS_ACLK);
            done = s_axi_arready;
            @(posedge AXIS_ACLK);
            cyc++;
            if (!done && cyc > TIMEOUT) report_timeout("the read address");
        end
        s_axi_arvalid <= 1'b0;
        s_axi_rready  <= 1'b1;
        done = 1'b0;
        cyc  = 0;
        while (!done && !hung) begin
            @(negedge AXIS_ACLK);
            if (s_axi_rvalid) begin
                done     = 1'b1;
                data     = s_axi_rdata;
                resp_acc = resp_acc | s_axi_rresp;
            end
            @(posedge AXIS_ACLK);
            cyc++;
            if (!done && cyc > TIMEOUT) report_timeout("read data");
        end
        s_axi_rready <= 1'b0;
    endtask

    // --------------------
    // stream side
    // --------------------
    // n indices in and one result beat out
    task automatic run_bundle(input logic stall, input int n, input logic [15:0] idx_list,
                              output logic [63:0] result, output logic got_last,
                              output logic ready_leak);
        logic done;
        int   cyc;
        int   i;
        result     = '0;
        got_last   = 1'b0;
        ready_leak = 1'b0;
        @(posedge AXIS_ACLK);
        for (i = 0; i < n && !hung; i++) begin
            s_axis_tdata  <= `HDC_IN_W'(idx_list[i*4 +: 4]);
            s_axis_tvalid <= 1'b1;
            s_axis_tlast  <= (i == n - 1);
            done = 1'b0;
            cyc  = 0;
            while (!done && !hung) begin
                @(negedge AXIS_ACLK);
                done = s_axis_tready;
                @(posedge AXIS_ACLK);
                cyc++;
                if (!done && cyc > TIMEOUT) report_timeout("input stream ready");
            end
        end
        s_axis_tvalid <= 1'b0;
        s_axis_tlast  <= 1'b0;
        done = 1'b0;
        cyc  = 0;
        while (!done && !hung) begin
            // one LFSR bit per cycle of back-pressure
            if (stall) begin
                lfsr = lfsr_next(lfsr);
                m_axis_tready <= lfsr[0];
            end else begin
                m_axis_tready <= 1'b1;
            end
            @(negedge AXIS_ACLK);
            if (m_axis_tvalid) begin
                // input must stay stalled while a result is pending
                ready_leak = ready_leak | s_axis_tready;
                if (m_axis_tready) begin
                    done     = 1'b1;
                    result   = m_axis_tdata;
                    got_last = m_axis_tlast;
                end
            end
            @(posedge AXIS_ACLK);
            cyc++;
            if (!done && cyc > TIMEOUT) report_timeout("the bundled result");
        end
        m_axis_tready <= 1'b0;
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        errors   = 0;
        checks   = 0;
        tests    = 0;
        hung     = 1'b0;
        lfsr     = 8'd36;
        resp_acc = 2'b00;
        S_AXI_ARESETN <= 1'b0;
        s_axi_awaddr  <= '0;
        s_axi_awvalid <= 1'b0;
        s_axi_wdata   <= '0;
        s_axi_wvalid  <= 1'b0;
        s_axi_bready  <= 1'b0;
        s_axi_araddr  <= '0;
        s_axi_arvalid <= 1'b0;
        s_axi_rready  <= 1'b0;
        s_axis_tdata  <= '0;
        s_axis_tvalid <= 1'b0;
        s_axis_tlast  <= 1'b0;
        m_axis_tready <= 1'b0;
        repeat (8) @(posedge AXIS_ACLK);
        S_AXI_ARESETN <= 1'b1;

        fd = $fopen("bench/hdc_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file bench/hdc_tests.txt");
            errors++;
        end else begin
            while (!hung && $fgets(line, fd) > 0) begin
                r = $sscanf(line, "%s %s %h %h %h %h %h %h %h",
                            name, kind, a, b, c, d, e, f, expv);
                // comment and blank lines do not parse to all nine fields
                if (r == 9) begin
                    errs_before = errors;
                    tests++;
                    resp_acc = 2'b00;
                    if (kind == 64'("reg")) begin
                        if (a[0]) axil_write(b, c);
                        axil_read(b, rd);
                        check_value(name, expv, 64'(rd));
                        // every transfer answers OKAY
                        check_value(name, 64'd0, 64'(resp_acc));
                    end else if (kind == 64'("gen")) begin
                        axil_write(`HDC_REG_NUM, a);
                        axil_write(`HDC_REG_CTRL, b);
                        // gen bit drops once the tie vector is built
                        rd    = 32'd1;
                        polls = 0;
                        while (rd[0] && !hung) begin
                            axil_read(`HDC_REG_CTRL, rd);
                            polls++;
                            if (rd[0] && polls > 50) report_timeout("gen to clear");
                        end
                        check_value(name, expv, 64'(rd));
                        check_value(name, 64'd0, 64'(resp_acc));
                    end else if (kind == 64'("bundle")) begin
                        run_bundle(a[0], b, {f[3:0], e[3:0], d[3:0], c[3:0]}, res, last, leak);
                        check_value(name, expv, res);
                        check_value(name, 64'd1, 64'(last));
                        check_value(name, 64'd0, 64'(leak));
                    end else begin
                        $display("test %0s has an unknown kind %0s", name, kind);
                        errors++;
                    end
                    if (errors == errs_before && !hung) begin
                        $display("%0s: ok", name);
                    end else begin
                        $display("%0s: mismatch", name);
                    end
                end
            end
            $fclose(fd);
        end

        $display("%0d tests, %0d checks, %0d errors, timeout %0d", tests, checks, errors, hung);
        if (errors == 0 && !hung && tests > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdc_accel.f */
+incdir+hdl
hdl/hdc_pkg.sv
hdl/axil_regs.sv
hdl/item_gen.sv
hdl/item_memory.sv
hdl/bundler.sv
hdl/hdc_accel.sv
bench/tb_hdc_accel.sv

/* hdl/axil_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hdc_cfg.svh"

module axil_regs (
    input  wire            AXIS_ACLK,
    input  wire            S_AXI_ARESETN,
    input  wire  [31:0]    s_axi_awaddr,
    input  wire            s_axi_awvalid,
    output logic           s_axi_awready,
    input  wire  [31:0]    s_axi_wdata,
    input  wire            s_axi_wvalid,
    output logic           s_axi_wready,
    input  wire            s_axi_bready,
    output logic [1:0]     s_axi_bresp,
    output logic           s_axi_bvalid,
    input  wire  [31:0]    s_axi_araddr,
    input  wire            s_axi_arvalid,
    output logic           s_axi_arready,
    input  wire            s_axi_rready,
    output logic [31:0]    s_axi_rdata,
    output logic [1:0]     s_axi_rresp,
    output logic           s_axi_rvalid,
    input  wire            gen_done,
    output logic           run,
    output logic           gen,
    output hdc_pkg::idx_t  item_num
);

    hdc_pkg::axil_state_t state;

    // captured address / data
    logic [31:0] waddr_q;
    logic [31:0] wdata_q;
    logic [31:0] raddr_q;

    // write commit, from live bus or captured half
    logic        wr_fire;
    logic [31:0] wr_addr_sel;
    logic [31:0] wr_data_sel;

    // --------------------
    // channel handshakes
    // --------------------

    // always OKAY
    assign s_axi_bresp   = 2'b00;
    assign s_axi_rresp   = 2'b00;
    assign s_axi_awready = (state == hdc_pkg::idle) | (state == hdc_pkg::got_data);
    assign s_axi_wready  = (state == hdc_pkg::idle) | (state == hdc_pkg::got_addr);
    // writes win in idle, so hold off AR while a write is pending
    assign s_axi_arready = (state == hdc_pkg::idle) & ~s_axi_awvalid & ~s_axi_wvalid;
    assign s_axi_bvalid  = (state == hdc_pkg::write_resp);
    assign s_axi_rvalid  = (state == hdc_pkg::read_resp);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= hdc_pkg::idle;
        end else begin
            case (state)
                hdc_pkg::idle: begin
                    if (s_axi_awvalid & s_axi_wvalid) begin
                        state <= hdc_pkg::write_resp;
                    end else if (s_axi_awvalid) begin
                        state <= hdc_pkg::got_addr;
                    end else if (s_axi_wvalid) begin
                        state <= hdc_pkg::got_data;
                    end else if (s_axi_arvalid) begin
                        state <= hdc_pkg::read_fetch;
                    end
                end
                hdc_pkg::got_addr:   if (s_axi_wvalid)  state <= hdc_pkg::write_resp;
                hdc_pkg::got_data:   if (s_axi_awvalid) state <= hdc_pkg::write_resp;
                hdc_pkg::write_resp: if (s_axi_bready)  state <= hdc_pkg::idle;
                // one cycle to fetch the register
                hdc_pkg::read_fetch: state <= hdc_pkg::read_resp;
                hdc_pkg::read_resp:  if (s_axi_rready)  state <= hdc_pkg::idle;
                default:             state <= hdc_pkg::idle;
            endcase
        end
    end

    // address and data latches
    always_ff @(posedge AXIS_ACLK) begin
        if (s_axi_awvalid & s_axi_awready) waddr_q <= s_axi_awaddr;
        if (s_axi_wvalid & s_axi_wready)   wdata_q <= s_axi_wdata;
        if (s_axi_arvalid & s_axi_arready) raddr_q <= s_axi_araddr;
    end

    // --------------------
    // register file
    // --------------------

    // commit on the edge that enters write_resp
    always_comb begin
        wr_fire     = 1'b0;
        wr_addr_sel = waddr_q;
        wr_data_sel = wdata_q;
        case (state)
            hdc_pkg::idle: begin
                wr_fire     = s_axi_awvalid & s_axi_wvalid;
                wr_addr_sel = s_axi_awaddr;
                wr_data_sel = s_axi_wdata;
            end
            hdc_pkg::got_addr: begin
                wr_fire     = s_axi_wvalid;
                wr_data_sel = s_axi_wdata;
            end
            hdc_pkg::got_data: begin
                wr_fire     = s_axi_awvalid;
                wr_addr_sel = s_axi_awaddr;
            end
            default: ;
        endcase
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            run      <= 1'b0;
            gen      <= 1'b0;
            item_num <= '0;
        end else begin
            // generator finished, self-clear
            if (gen_done) gen <= 1'b0;
            // a software write in the same cycle takes priority
            if (wr_fire) begin
                if (wr_addr_sel == `HDC_REG_CTRL) begin
                    {run, gen} <= wr_data_sel[1:0];
                end else if (wr_addr_sel == `HDC_REG_NUM) begin
                    item_num <= wr_data_sel[`HDC_IDX_W-1:0];
                end
            end
        end
    end

    // read mux, unmapped reads as zero
    always_ff @(posedge AXIS_ACLK) begin
        if (state == hdc_pkg::read_fetch) begin
            if (raddr_q == `HDC_REG_CTRL) begin
                s_axi_rdata <= {30'd0, run, gen};
            end else if (raddr_q == `HDC_REG_NUM) begin
                s_axi_rdata <= 32'(item_num);
            end else begin
                s_axi_rdata <= 32'd0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/bundler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hdc_cfg.svh"

module bundler (
    input  wire                  AXIS_ACLK,
    input  wire                  S_AXI_ARESETN,
    input  wire                  run,
    input  wire                  gen,
    input  hdc_pkg::hv_t         tie_vec,
    input  hdc_pkg::hv_t         rd_data,
    input  wire [`HDC_IN_W-1:0]  s_axis_tdata,
    input  wire                  s_axis_tvalid,
    input  wire                  s_axis_tlast,
    output logic                 s_axis_tready,
    output hdc_pkg::idx_t        rd_addr,
    input  wire                  m_axis_tready,
    output hdc_pkg::hv_t         m_axis_tdata,
    output logic                 m_axis_tvalid,
    output logic                 m_axis_tlast
);

    hdc_pkg::bundle_state_t state;

    // per-dimension ones count
    logic [`HDC_CNT_W-1:0] cnt_q [`HDC_DIM];
    // vectors accumulated so far
    logic [`HDC_CNT_W-1:0] n_q;
    // memory read in flight, data arrives next cycle
    logic                  acc_v;
    logic                  in_hs;
    hdc_pkg::hv_t          maj;

    // --------------------
    // stream handshakes
    // --------------------
    assign s_axis_tready = run & ~gen & (state == hdc_pkg::collect);
    assign in_hs         = s_axis_tvalid & s_axis_tready;
    // index goes straight to the memory address
    assign rd_addr       = s_axis_tdata[`HDC_IDX_W-1:0];
    // single-beat result
    assign m_axis_tvalid = (state == hdc_pkg::hold);
    assign m_axis_tlast  = (state == hdc_pkg::hold);

    // majority, ties from tie_vec
    always_comb begin
        for (int d = 0; d < `HDC_DIM; d++) begin
            if ({cnt_q[d], 1'b0} > {1'b0, n_q}) begin
                maj[d] = 1'b1;
            end else if ({cnt_q[d], 1'b0} == {1'b0, n_q}) begin
                maj[d] = tie_vec[d];
            end else begin
                maj[d] = 1'b0;
            end
        end
    end

    // --------------------
    // counters and FSM
    // --------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !run) begin
            state <= hdc_pkg::collect;
            acc_v <= 1'b0;
            n_q   <= '0;
            for (int d = 0; d < `HDC_DIM; d++) cnt_q[d] <= '0;
        end else begin
            acc_v <= in_hs;
            // add the returned item vector
            if (acc_v) begin
                n_q <= n_q + 1'b1;
                for (int d = 0; d < `HDC_DIM; d++) begin
                    cnt_q[d] <= cnt_q[d] + `HDC_CNT_W'(rd_data[d]);
                end
            end
            case (state)
                hdc_pkg::collect: if (in_hs & s_axis_tlast) state <= hdc_pkg::finish;
                // wait for the last read to land
                hdc_pkg::finish:  if (!acc_v) state <= hdc_pkg::hold;
                hdc_pkg::hold: begin
                    if (m_axis_tready) begin
                        state <= hdc_pkg::collect;
                        n_q   <= '0;
                        for (int d = 0; d < `HDC_DIM; d++) cnt_q[d] <= '0;
                    end
                end
                default: state <= hdc_pkg::collect;
            endcase
        end
    end

    // result register, loaded once counts are final
    always_ff @(posedge AXIS_ACLK) begin
        if (state == hdc_pkg::finish && !acc_v) begin
            m_axis_tdata <= maj;
        end
    end

endmodule

`default_nettype wire

/* hdl/hdc_accel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hdc_cfg.svh"

module hdc_accel (
    input  wire                  AXIS_ACLK,
    input  wire                  S_AXI_ARESETN,
    // axi-lite slave
    input  wire  [31:0]          s_axi_awaddr,
    input  wire                  s_axi_awvalid,
    output wire                  s_axi_awready,
    input  wire  [31:0]          s_axi_wdata,
    input  wire                  s_axi_wvalid,
    output wire                  s_axi_wready,
    input  wire                  s_axi_bready,
    output wire  [1:0]           s_axi_bresp,
    output wire                  s_axi_bvalid,
    input  wire  [31:0]          s_axi_araddr,
    input  wire                  s_axi_arvalid,
    output wire                  s_axi_arready,
    input  wire                  s_axi_rready,
    output wire  [31:0]          s_axi_rdata,
    output wire  [1:0]           s_axi_rresp,
    output wire                  s_axi_rvalid,
    // axi-stream slave, item indices
    input  wire  [`HDC_IN_W-1:0] s_axis_tdata,
    input  wire                  s_axis_tvalid,
    input  wire                  s_axis_tlast,
    output wire                  s_axis_tready,
    // axi-stream master, bundled vector
    output wire  [`HDC_DIM-1:0]  m_axis_tdata,
    output wire                  m_axis_tvalid,
    output wire                  m_axis_tlast,
    input  wire                  m_axis_tready
);

    // control
    wire                run;
    wire                gen;
    wire                gen_done;
    wire hdc_pkg::idx_t item_num;
    // generator to memory
    wire                wr_en;
    wire hdc_pkg::idx_t wr_addr;
    wire hdc_pkg::hv_t  wr_data;
    wire hdc_pkg::hv_t  tie_vec;
    // bundler read port
    wire hdc_pkg::idx_t rd_addr;
    wire hdc_pkg::hv_t  rd_data;

    axil_regs u_regs (
        .AXIS_ACLK, .S_AXI_ARESETN,
        .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
        .s_axi_wdata, .s_axi_wvalid, .s_axi_wready,
        .s_axi_bready, .s_axi_bresp, .s_axi_bvalid,
        .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
        .s_axi_rready, .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid,
        .gen_done, .run, .gen, .item_num
    );

    item_gen u_gen (
        .AXIS_ACLK, .S_AXI_ARESETN, .gen, .item_num,
        .wr_en, .wr_addr, .wr_data, .tie_vec, .gen_done
    );

    item_memory u_mem (
        .AXIS_ACLK, .wr_en, .wr_addr, .wr_data, .rd_addr, .rd_data
    );

    bundler u_bundler (
        .AXIS_ACLK, .S_AXI_ARESETN, .run, .gen, .tie_vec, .rd_data,
        .s_axis_tdata, .s_axis_tvalid, .s_axis_tlast, .s_axis_tready,
        .rd_addr, .m_axis_tready, .m_axis_tdata, .m_axis_tvalid, .m_axis_tlast
    );

endmodule

`default_nettype wire

/* hdl/hdc_cfg.svh */
`ifndef HDC_CFG_SVH
`define HDC_CFG_SVH

// hypervector geometry
`define HDC_DIM      64
`define HDC_WORD     32
`define HDC_WORDS    2
`define HDC_ITEMS    16
`define HDC_IDX_W    4
// up to 31 inputs per bundle
`define HDC_CNT_W    5
// stream input, index in the low bits
`define HDC_IN_W     16
`define HDC_XS_SEED  32'd2463534242
// axi-lite register map
`define HDC_REG_CTRL 32'h0000_0000
`define HDC_REG_NUM  32'h0000_0004

`endif

/* hdl/hdc_pkg.sv */
`default_nettype none

`include "hdc_cfg.svh"

package hdc_pkg;

    // axi-lite slave states
    typedef enum logic [2:0] {
        idle, got_addr, got_data, write_resp, read_fetch, read_resp
    } axil_state_t;

    // bundler states
    typedef enum logic [1:0] {
        collect, finish, hold
    } bundle_state_t;

    typedef logic [`HDC_DIM-1:0]   hv_t;
    typedef logic [`HDC_IDX_W-1:0] idx_t;

endpackage

`default_nettype wire

/* hdl/item_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hdc_cfg.svh"

module item_gen (
    input  wire            AXIS_ACLK,
    input  wire            S_AXI_ARESETN,
    input  wire            gen,
    input  hdc_pkg::idx_t  item_num,
    output logic           wr_en,
    output hdc_pkg::idx_t  wr_addr,
    output hdc_pkg::hv_t   wr_data,
    output hdc_pkg::hv_t   tie_vec,
    output logic           gen_done
);

    localparam int WC_W = (`HDC_WORDS > 1) ? $clog2(`HDC_WORDS) : 1;

    logic [`HDC_WORD-1:0]         xs_q;
    logic [`HDC_WORD-1:0]         xs_next;
    logic [WC_W-1:0]              word_cnt;
    // one extra bit, the tie vector sits at item_num+1
    logic [`HDC_IDX_W:0]          vec_cnt;
    // lower words of the vector being built
    logic [`HDC_DIM-`HDC_WORD-1:0] asm_q;
    hdc_pkg::hv_t                 vec_full;
    logic                         word_last;
    logic                         vec_is_tie;

    // xorshift32, shifts 13/17/5
    function automatic logic [`HDC_WORD-1:0] xorshift32(input logic [`HDC_WORD-1:0] x);
        logic [`HDC_WORD-1:0] t;
        t = x ^ (x << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    assign xs_next    = xorshift32(xs_q);
    assign word_last  = (word_cnt == WC_W'(`HDC_WORDS - 1));
    assign vec_is_tie = (vec_cnt == ({1'b0, item_num} + 1'b1));
    // top word comes straight from the generator
    assign vec_full   = {xs_next, asm_q};
    // combinational so gen drops right after the last word
    assign gen_done   = gen & word_last & vec_is_tie;

    // --------------------
    // sequencing
    // --------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            // restart from the seed on every gen
            xs_q     <= `HDC_XS_SEED;
            word_cnt <= '0;
            vec_cnt  <= '0;
            wr_en    <= 1'b0;
        end else begin
            xs_q  <= xs_next;
            wr_en <= word_last & ~vec_is_tie;
            if (word_last) begin
                word_cnt <= '0;
                vec_cnt  <= vec_cnt + 1'b1;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // word assembly, lowest word first
    always_ff @(posedge AXIS_ACLK) begin
        if (gen && !word_last) begin
            asm_q[word_cnt*`HDC_WORD +: `HDC_WORD] <= xs_next;
        end
        if (gen && word_last) begin
            if (vec_is_tie) begin
                tie_vec <= vec_full;
            end else begin
                wr_addr <= vec_cnt[`HDC_IDX_W-1:0];
                wr_data <= vec_full;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/item_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hdc_cfg.svh"

module item_memory (
    input  wire            AXIS_ACLK,
    input  wire            wr_en,
    input  hdc_pkg::idx_t  wr_addr,
    input  hdc_pkg::hv_t   wr_data,
    input  hdc_pkg::idx_t  rd_addr,
    output hdc_pkg::hv_t   rd_data
);

    // item hypervectors, one per index
    hdc_pkg::hv_t mem [`HDC_ITEMS];

    // --------------------
    // write port
    // --------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // --------------------
    // read port
    // --------------------
    // registered, one cycle latency
    always_ff @(posedge AXIS_ACLK) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the hdc_accel testbench

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module tb_hdc_accel -f hdc_accel.f -o tb_hdc_accel
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_hdc_accel > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test passed" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
